//--- src/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // Datapath and CSR port widths
    localparam int DATA_W     = 32;
    localparam int CSR_ADDR_W = 14;

    // CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

    // Exception codes
    localparam int                 ECODE_W   = 6;
    localparam logic [ECODE_W-1:0] ECODE_INT = 6'h00;

    // Interrupt lines: 1:0 software, 9:2 hardware, 11 timer
    localparam int INT_NUM = 13;
    localparam int SWI_NUM = 2;
    localparam int HWI_LSB = 2;
    localparam int HWI_NUM = 8;
    localparam int TI_BIT  = 11;

    // CRMD / PRMD fields
    localparam int PLV_W  = 2;
    localparam int IE_BIT = 2; // CRMD.IE and PRMD.PIE share the position

    // ESTAT and EENTRY fields
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int EENTRY_LSB      = 6;

    // Timer configuration fields
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INIT_LSB     = 2;
    localparam int TICLR_CLR_BIT     = 0;

    // Pipeline: if1, if2, id, ex, mem1, mem2, wb
    localparam int NUM_STAGES = 7;
    localparam int NUM_FLUSH  = 5; // if1 to mem1
    localparam int STG_ID     = 2;
    localparam int STG_EX     = 3;

endpackage

`default_nettype wire

//--- src/trap_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr_regs (
    input  wire                                 clk,
    input  wire                                 rst_n,
    // Software access port
    input  wire  [trap_pkg::CSR_ADDR_W-1:0]     csr_addr_i,
    input  wire                                 csr_we_i,
    input  wire  [trap_pkg::DATA_W-1:0]         csr_wdata_i,
    output logic [trap_pkg::DATA_W-1:0]         csr_rdata_o,
    output logic                                csr_bad_addr_o,
    // Updates from the trap controller
    input  wire                                 trap_take_i,
    input  wire  [trap_pkg::ECODE_W-1:0]        trap_ecode_i,
    input  wire  [trap_pkg::DATA_W-1:0]         trap_pc_i,
    input  wire                                 ertn_take_i,
    // Interrupt sources
    input  wire  [trap_pkg::HWI_NUM-1:0]        hwi_i,
    input  wire                                 ti_i,
    // Timer side
    input  wire  [trap_pkg::DATA_W-1:0]         tval_i,
    output logic                                ti_clr_o,
    output logic [trap_pkg::DATA_W-1:0]         tcfg_o,
    output logic                                tcfg_we_o,
    // To the trap controller
    output logic [trap_pkg::INT_NUM-1:0]        int_pend_o,
    output logic                                ie_o,
    output logic [trap_pkg::DATA_W-1:0]         eentry_o,
    output logic [trap_pkg::DATA_W-1:0]         era_o
);

    logic [trap_pkg::PLV_W-1:0]                     crmd_plv_q;
    logic                                           crmd_ie_q;
    logic [trap_pkg::PLV_W-1:0]                     prmd_pplv_q;
    logic                                           prmd_pie_q;
    logic [trap_pkg::INT_NUM-1:0]                   ecfg_lie_q;
    logic [trap_pkg::SWI_NUM-1:0]                   estat_swi_q;
    logic [trap_pkg::HWI_NUM-1:0]                   estat_hwi_q;
    logic [trap_pkg::ECODE_W-1:0]                   estat_ecode_q;
    logic [trap_pkg::DATA_W-1:0]                    era_q;
    logic [trap_pkg::DATA_W-1:trap_pkg::EENTRY_LSB] eentry_q;
    logic [trap_pkg::DATA_W-1:0]                    tcfg_q;
    logic [trap_pkg::INT_NUM-1:0]                   estat_is;

    // Write strobes; an unknown address matches none of them
    logic wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_eentry;
    assign wr_crmd   = csr_we_i && (csr_addr_i == trap_pkg::CSR_CRMD);
    assign wr_prmd   = csr_we_i && (csr_addr_i == trap_pkg::CSR_PRMD);
    assign wr_ecfg   = csr_we_i && (csr_addr_i == trap_pkg::CSR_ECFG);
    assign wr_estat  = csr_we_i && (csr_addr_i == trap_pkg::CSR_ESTAT);
    assign wr_era    = csr_we_i && (csr_addr_i == trap_pkg::CSR_ERA);
    assign wr_eentry = csr_we_i && (csr_addr_i == trap_pkg::CSR_EENTRY);
    assign tcfg_we_o = csr_we_i && (csr_addr_i == trap_pkg::CSR_TCFG);
    assign ti_clr_o  = csr_we_i && (csr_addr_i == trap_pkg::CSR_TICLR)
                       && csr_wdata_i[trap_pkg::TICLR_CLR_BIT];

    always_comb begin
        estat_is = '0;
        estat_is[trap_pkg::SWI_NUM-1:0] = estat_swi_q;
        estat_is[trap_pkg::HWI_LSB +: trap_pkg::HWI_NUM] = estat_hwi_q;
        estat_is[trap_pkg::TI_BIT] = ti_i;
    end

    always_comb begin
        csr_rdata_o    = '0;
        csr_bad_addr_o = 1'b0;
        case (csr_addr_i)
            trap_pkg::CSR_CRMD:   csr_rdata_o[trap_pkg::IE_BIT:0] = {crmd_ie_q, crmd_plv_q};
            trap_pkg::CSR_PRMD:   csr_rdata_o[trap_pkg::IE_BIT:0] = {prmd_pie_q, prmd_pplv_q};
            trap_pkg::CSR_ECFG:   csr_rdata_o[trap_pkg::INT_NUM-1:0] = ecfg_lie_q;
            trap_pkg::CSR_ESTAT: begin
                csr_rdata_o[trap_pkg::INT_NUM-1:0] = estat_is;
                csr_rdata_o[trap_pkg::ESTAT_ECODE_LSB +: trap_pkg::ECODE_W] = estat_ecode_q;
            end
            trap_pkg::CSR_ERA:    csr_rdata_o = era_q;
            trap_pkg::CSR_EENTRY: csr_rdata_o = eentry_o;
            trap_pkg::CSR_TCFG:   csr_rdata_o = tcfg_q;
            trap_pkg::CSR_TVAL:   csr_rdata_o = tval_i;
            trap_pkg::CSR_TICLR:  csr_rdata_o = '0; // Write-only clear
            default:              csr_bad_addr_o = 1'b1;
        endcase
    end

    // Trap entry and ertn win over a same-cycle software write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_plv_q  <= '0;
            crmd_ie_q   <= 1'b0;
            prmd_pplv_q <= '0;
            prmd_pie_q  <= 1'b0;
        end else if (trap_take_i) begin
            prmd_pplv_q <= crmd_plv_q; // Save current mode
            prmd_pie_q  <= crmd_ie_q;
            crmd_plv_q  <= '0;
            crmd_ie_q   <= 1'b0;
        end else if (ertn_take_i) begin
            crmd_plv_q <= prmd_pplv_q;
            crmd_ie_q  <= prmd_pie_q;
        end else begin
            if (wr_crmd) begin
                crmd_plv_q <= csr_wdata_i[trap_pkg::PLV_W-1:0];
                crmd_ie_q  <= csr_wdata_i[trap_pkg::IE_BIT];
            end
            if (wr_prmd) begin
                prmd_pplv_q <= csr_wdata_i[trap_pkg::PLV_W-1:0];
                prmd_pie_q  <= csr_wdata_i[trap_pkg::IE_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ecfg_lie_q    <= '0;
            estat_swi_q   <= '0;
            estat_hwi_q   <= '0;
            estat_ecode_q <= '0;
            era_q         <= '0;
            eentry_q      <= '0;
            tcfg_q        <= '0;
        end else begin
            estat_hwi_q <= hwi_i; // Sampled every cycle
            if (wr_ecfg) ecfg_lie_q <= csr_wdata_i[trap_pkg::INT_NUM-1:0];
            if (wr_estat) estat_swi_q <= csr_wdata_i[trap_pkg::SWI_NUM-1:0];
            if (wr_eentry) eentry_q <= csr_wdata_i[trap_pkg::DATA_W-1:trap_pkg::EENTRY_LSB];
            if (tcfg_we_o) tcfg_q <= csr_wdata_i;
            if (trap_take_i) begin
                estat_ecode_q <= trap_ecode_i;
                era_q         <= trap_pc_i;
            end else if (wr_era) begin
                era_q <= csr_wdata_i;
            end
        end
    end

    // Timer sees the value being written in the write cycle itself
    assign tcfg_o     = tcfg_we_o ? csr_wdata_i : tcfg_q;
    assign int_pend_o = estat_is & ecfg_lie_q;
    assign ie_o       = crmd_ie_q;
    assign eentry_o   = {eentry_q, {trap_pkg::EENTRY_LSB{1'b0}}};
    assign era_o      = era_q;

    // Trap and ertn decisions are exclusive in the controller
    a_trap_ertn_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_take_i && ertn_take_i));

endmodule

`default_nettype wire

//--- src/trap_timer.sv
`timescale 1ns/1ps
`default_nettype none

module trap_timer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [trap_pkg::DATA_W-1:0]  tcfg_i,
    input  wire                          tcfg_we_i,
    input  wire                          ti_clr_i,
    output logic                         ti_o,
    output logic [trap_pkg::DATA_W-1:0]  tval_o
);

    logic [trap_pkg::DATA_W-1:0] init_val;
    logic                        timer_en;
    logic                        periodic;
    logic                        expire;

    assign init_val = {tcfg_i[trap_pkg::DATA_W-1:trap_pkg::TCFG_INIT_LSB],
                       {trap_pkg::TCFG_INIT_LSB{1'b0}}};
    assign timer_en = tcfg_i[trap_pkg::TCFG_EN_BIT];
    assign periodic = tcfg_i[trap_pkg::TCFG_PERIODIC_BIT];
    assign expire   = timer_en && !tcfg_we_i && (tval_o == 32'd1); // Next value is zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tval_o <= '0;
        end else if (tcfg_we_i) begin
            tval_o <= init_val;
        end else if (timer_en) begin
            if (tval_o != '0) tval_o <= tval_o - 32'd1;
            else if (periodic) tval_o <= init_val; // One-shot stays at zero
        end
    end

    // Sticky until cleared
    always_ff @(posedge clk) begin
        if (!rst_n) ti_o <= 1'b0;
        else if (expire) ti_o <= 1'b1; // New expiry wins over the clear
        else if (ti_clr_i) ti_o <= 1'b0;
    end

    // Rises only as TVAL counts into zero, and a disabled timer does not count
    a_ti_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ti_o) |-> ($past(tval_o) != '0) && (tval_o == '0));

endmodule

`default_nettype wire

//--- src/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  wire                                 clk,
    input  wire                                 rst_n,
    // Committing instruction
    input  wire                                 cmt_valid_i,
    input  wire                                 cmt_excp_i,
    input  wire  [trap_pkg::ECODE_W-1:0]        cmt_ecode_i,
    input  wire  [trap_pkg::DATA_W-1:0]         cmt_pc_i,
    input  wire                                 cmt_ertn_i,
    input  wire                                 cmt_idle_i,
    // CSR state
    input  wire  [trap_pkg::INT_NUM-1:0]        int_pend_i,
    input  wire                                 ie_i,
    input  wire  [trap_pkg::DATA_W-1:0]         eentry_i,
    input  wire  [trap_pkg::DATA_W-1:0]         era_i,
    // CSR update strobes
    output logic                                trap_take_o,
    output logic [trap_pkg::ECODE_W-1:0]        trap_ecode_o,
    output logic [trap_pkg::DATA_W-1:0]         trap_pc_o,
    output logic                                ertn_take_o,
    // Pipeline control
    output logic                                redirect_valid_o,
    output logic [trap_pkg::DATA_W-1:0]         redirect_pc_o,
    output logic                                trap_flush_o,
    output logic                                idle_set_o,
    output logic                                idle_clr_o
);

    logic int_pending;
    logic int_take;
    logic excp_take;
    logic idle_wait_q;

    // Local enable only, the wake-up from idle ignores CRMD.IE
    assign int_pending = |int_pend_i;

    // Interrupt before exception before ertn
    assign int_take    = cmt_valid_i && ie_i && int_pending;
    assign excp_take   = cmt_valid_i && cmt_excp_i && !int_take;
    assign trap_take_o = int_take || excp_take;
    assign ertn_take_o = cmt_valid_i && cmt_ertn_i && !trap_take_o;

    assign trap_ecode_o = int_take ? trap_pkg::ECODE_INT : cmt_ecode_i;
    assign trap_pc_o    = cmt_pc_i;

    always_comb begin
        redirect_valid_o = 1'b0;
        redirect_pc_o    = '0;
        if (trap_take_o) begin
            redirect_valid_o = 1'b1;
            redirect_pc_o    = eentry_i;
        end else if (ertn_take_o) begin
            redirect_valid_o = 1'b1;
            redirect_pc_o    = era_i;
        end
    end

    assign trap_flush_o = redirect_valid_o; // Both trap and ertn drain if1..mem1

    // An idle that traps on its own commit never enters the wait
    assign idle_set_o = cmt_valid_i && cmt_idle_i && !trap_take_o;
    assign idle_clr_o = idle_wait_q && int_pending;

    always_ff @(posedge clk) begin
        if (!rst_n) idle_wait_q <= 1'b0;
        else if (idle_set_o) idle_wait_q <= 1'b1;
        else if (idle_clr_o) idle_wait_q <= 1'b0;
    end

    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_valid_i |-> !(cmt_excp_i && cmt_ertn_i));

endmodule

`default_nettype wire

//--- src/pipe_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_flush_ctrl (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  trap_flush_i,
    input  wire                                  modify_state_i,
    input  wire                                  bp_miss_i,
    input  wire                                  idle_set_i,
    input  wire                                  idle_clr_i,
    input  wire  [trap_pkg::NUM_STAGES-1:1]      stall_req_i, // if1 has no upstream stage
    output logic [trap_pkg::NUM_STAGES-1:0]      flush_o,
    output logic [trap_pkg::NUM_STAGES-1:0]      stall_o
);

    logic idle_q;

    always_ff @(posedge clk) begin
        if (!rst_n) idle_q <= 1'b0;
        else if (idle_set_i) idle_q <= 1'b1;
        else if (idle_clr_i) idle_q <= 1'b0;
    end

    // mem2 and wb are past the commit point and never flush
    always_comb begin
        flush_o = '0;
        for (int k = 0; k < trap_pkg::NUM_FLUSH; k++) begin
            flush_o[k] = trap_flush_i
                       | (modify_state_i & (k <= trap_pkg::STG_EX))
                       | (bp_miss_i & (k <= trap_pkg::STG_ID));
        end
    end

    // Each stage holds when the next one holds
    assign stall_o = {1'b0,
                      stall_req_i[trap_pkg::NUM_STAGES-1:2],
                      stall_req_i[1] | idle_q};

    a_flush_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_o[trap_pkg::NUM_STAGES-1:1] & ~flush_o[trap_pkg::NUM_STAGES-2:0]) == '0);

endmodule

`default_nettype wire

//--- src/trap_top.sv
`timescale 1ns/1ps
`default_nettype none

module trap_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [trap_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
    input  wire                                  csr_we_i,
    input  wire  [trap_pkg::DATA_W-1:0]          csr_wdata_i,
    input  wire                                  cmt_valid_i,
    input  wire                                  cmt_excp_i,
    input  wire  [trap_pkg::ECODE_W-1:0]         cmt_ecode_i,
    input  wire  [trap_pkg::DATA_W-1:0]          cmt_pc_i,
    input  wire                                  cmt_ertn_i,
    input  wire                                  cmt_idle_i,
    input  wire  [trap_pkg::HWI_NUM-1:0]         hwi_i,
    input  wire                                  bp_miss_i,
    input  wire                                  modify_state_i,
    input  wire  [trap_pkg::NUM_STAGES-1:1]      stall_req_i,
    output logic [trap_pkg::DATA_W-1:0]          csr_rdata_o,
    output logic                                 csr_bad_addr_o,
    output logic                                 redirect_valid_o,
    output logic [trap_pkg::DATA_W-1:0]          redirect_pc_o,
    output logic [trap_pkg::NUM_STAGES-1:0]      flush_o,
    output logic [trap_pkg::NUM_STAGES-1:0]      stall_o
);

    logic                         trap_take;
    logic [trap_pkg::ECODE_W-1:0] trap_ecode;
    logic [trap_pkg::DATA_W-1:0]  trap_pc;
    logic                         ertn_take;
    logic [trap_pkg::INT_NUM-1:0] int_pend;
    logic                         ie;
    logic [trap_pkg::DATA_W-1:0]  eentry;
    logic [trap_pkg::DATA_W-1:0]  era;
    logic                         ti;
    logic                         ti_clr;
    logic [trap_pkg::DATA_W-1:0]  tval;
    logic [trap_pkg::DATA_W-1:0]  tcfg;
    logic                         tcfg_we;
    logic                         trap_flush;
    logic                         idle_set;
    logic                         idle_clr;

    trap_csr_regs i_csr_regs (
        .clk, .rst_n,
        .csr_addr_i, .csr_we_i, .csr_wdata_i,
        .csr_rdata_o, .csr_bad_addr_o,
        .trap_take_i(trap_take), .trap_ecode_i(trap_ecode),
        .trap_pc_i(trap_pc), .ertn_take_i(ertn_take),
        .hwi_i, .ti_i(ti), .tval_i(tval),
        .ti_clr_o(ti_clr), .tcfg_o(tcfg), .tcfg_we_o(tcfg_we),
        .int_pend_o(int_pend), .ie_o(ie), .eentry_o(eentry), .era_o(era)
    );

    trap_timer i_timer (
        .clk, .rst_n,
        .tcfg_i(tcfg), .tcfg_we_i(tcfg_we), .ti_clr_i(ti_clr),
        .ti_o(ti), .tval_o(tval)
    );

    trap_ctrl i_trap_ctrl (
        .clk, .rst_n,
        .cmt_valid_i, .cmt_excp_i, .cmt_ecode_i, .cmt_pc_i, .cmt_ertn_i, .cmt_idle_i,
        .int_pend_i(int_pend), .ie_i(ie), .eentry_i(eentry), .era_i(era),
        .trap_take_o(trap_take), .trap_ecode_o(trap_ecode),
        .trap_pc_o(trap_pc), .ertn_take_o(ertn_take),
        .redirect_valid_o, .redirect_pc_o,
        .trap_flush_o(trap_flush), .idle_set_o(idle_set), .idle_clr_o(idle_clr)
    );

    pipe_flush_ctrl i_flush_ctrl (
        .clk, .rst_n,
        .trap_flush_i(trap_flush), .modify_state_i, .bp_miss_i,
        .idle_set_i(idle_set), .idle_clr_i(idle_clr),
        .stall_req_i, .flush_o, .stall_o
    );

endmodule

`default_nettype wire

//--- testbench/tb_trap_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trap_top;

    localparam logic [2:0] OP_WR    = 3'd0; // CSR write
    localparam logic [2:0] OP_RD    = 3'd1; // CSR read and compare
    localparam logic [2:0] OP_CMT   = 3'd2;
    localparam logic [2:0] OP_HWI   = 3'd3;
    localparam logic [2:0] OP_WAIT  = 3'd4; // Poll until the masked value matches
    localparam logic [2:0] OP_PROBE = 3'd5;
    localparam int         WAIT_LIMIT = 200;

    // flags bit 0: redirect expected, bit 1: random pc, bit 2: expect the saved trap pc
    typedef struct packed {
        logic [2:0]                      test;
        logic [2:0]                      op;
        logic [trap_pkg::CSR_ADDR_W-1:0] addr;
        logic [31:0]                     data;
        logic [6:0]                      aux;
        logic [31:0]                     exp_val;
        logic [6:0]                      exp_aux;
        logic [2:0]                      flags;
    } step_t;

    logic                                clk;
    logic                                rst_n;
    logic [trap_pkg::CSR_ADDR_W-1:0]     csr_addr;
    logic                                csr_we;
    logic [31:0]                         csr_wdata;
    logic                                cmt_valid;
    logic                                cmt_excp;
    logic [trap_pkg::ECODE_W-1:0]        cmt_ecode;
    logic [31:0]                         cmt_pc;
    logic                                cmt_ertn;
    logic                                cmt_idle;
    logic [trap_pkg::HWI_NUM-1:0]        hwi;
    logic                                bp_miss;
    logic                                modify_state;
    logic [trap_pkg::NUM_STAGES-1:1]     stall_req;
    logic [31:0]                         csr_rdata;
    logic                                csr_bad_addr;
    logic                                redirect_valid;
    logic [31:0]                         redirect_pc;
    logic [trap_pkg::NUM_STAGES-1:0]     flush;
    logic [trap_pkg::NUM_STAGES-1:0]     stall;

    step_t       steps[$];
    logic [2:0]  tid;
    logic [2:0]  cur_test;
    logic [31:0] trap_pc_saved;
    int          checks;
    int          errors;
    int          test_err0;
    integer      seed = 32'hc590;

    trap_top i_trap_top (
        .clk(clk), .rst_n(rst_n),
        .csr_addr_i(csr_addr), .csr_we_i(csr_we), .csr_wdata_i(csr_wdata),
        .cmt_valid_i(cmt_valid), .cmt_excp_i(cmt_excp), .cmt_ecode_i(cmt_ecode),
        .cmt_pc_i(cmt_pc), .cmt_ertn_i(cmt_ertn), .cmt_idle_i(cmt_idle),
        .hwi_i(hwi), .bp_miss_i(bp_miss), .modify_state_i(modify_state),
        .stall_req_i(stall_req),
        .csr_rdata_o(csr_rdata), .csr_bad_addr_o(csr_bad_addr),
        .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc),
        .flush_o(flush), .stall_o(stall)
    );

    always #2 clk = ~clk;

    function automatic void add_step(input logic [2:0] op, input logic [13:0] addr,
                                     input logic [31:0] data, input logic [6:0] aux,
                                     input logic [31:0] exp_val, input logic [6:0] exp_aux,
                                     input logic [2:0] flags);
        step_t s;
        s = {tid, op, addr, data, aux, exp_val, exp_aux, flags};
        steps.push_back(s);
    endfunction

    // Stage k holds when stage k+1 requests, the last stage never holds
    function automatic logic [6:0] stall_from_req(input logic [6:0] req);
        return {1'b0, req[6:1]};
    endfunction

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1:    return "csr access";
            3'd2:    return "exception entry and ertn";
            3'd3:    return "interrupts";
            3'd4:    return "timer";
            3'd5:    return "idle wait";
            default: return "flush and stall";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        cmt_valid    = 1'b0;
        cmt_excp     = 1'b0;
        cmt_ecode    = '0;
        cmt_pc       = '0;
        cmt_ertn     = 1'b0;
        cmt_idle     = 1'b0;
        bp_miss      = 1'b0;
        modify_state = 1'b0;
        stall_req    = '0;
    endtask

    task automatic report_test(input logic [2:0] t);
        if (errors == test_err0) $display("Test %0d %s: ok", t, test_name(t));
        else $display("Test %0d %s: %0d errors", t, test_name(t), errors - test_err0);
    endtask

    // Entered 1 ns after a rising edge, returns 1 ns after a later one
    task automatic run_step(input step_t s);
        logic [31:0] exp_pc;
        logic [31:0] polled;
        int          waited;
        clear_inputs();
        case (s.op)
            OP_WR: begin
                csr_addr  = s.addr;
                csr_we    = 1'b1;
                csr_wdata = s.data;
            end
            OP_RD, OP_WAIT: csr_addr = s.addr;
            OP_CMT: begin
                cmt_valid = 1'b1;
                cmt_excp  = s.data[0];
                cmt_ertn  = s.data[1];
                cmt_idle  = s.data[2];
                cmt_ecode = s.aux[5:0];
                if (s.flags[1]) cmt_pc = $random(seed) & 32'hffff_fffc;
            end
            OP_HWI: hwi = s.data[7:0];
            OP_PROBE: begin
                bp_miss      = s.data[0];
                modify_state = s.data[1];
                stall_req    = s.aux[6:1];
            end
            default: ;
        endcase
        #1;
        exp_pc = s.flags[2] ? trap_pc_saved : s.exp_val;
        case (s.op)
            OP_RD: begin
                check_val("csr_rdata_o", csr_rdata, exp_pc);
                check_val("csr_bad_addr_o", 32'(csr_bad_addr), 32'(s.exp_aux[0]));
            end
            OP_CMT: begin
                check_val("redirect_valid_o", 32'(redirect_valid), 32'(s.flags[0]));
                if (s.flags[0]) check_val("redirect_pc_o", redirect_pc, exp_pc);
                check_val("flush_o", 32'(flush), 32'(s.exp_aux));
                if (s.flags[0] && !s.data[1]) trap_pc_saved = cmt_pc;
            end
            OP_WAIT: begin
                waited = 0;
                polled = s.aux[0] ? 32'(stall) : csr_rdata;
                while (((polled & s.data) != s.exp_val) && (waited < WAIT_LIMIT)) begin
                    @(posedge clk);
                    #1;
                    waited++;
                    polled = s.aux[0] ? 32'(stall) : csr_rdata;
                end
                checks++;
                if ((polled & s.data) != s.exp_val) begin
                    errors++;
                    $display("Timeout: value under mask %h never became %h in %0d cycles",
                             s.data, s.exp_val, WAIT_LIMIT);
                end
            end
            OP_PROBE: begin
                check_val("flush_o", 32'(flush), s.exp_val);
                check_val("stall_o", 32'(stall), 32'(s.exp_aux));
            end
            default: ;
        endcase
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        hwi    = '0;
        checks = 0;
        errors = 0;
        trap_pc_saved = '0;
        clear_inputs();

        tid = 3'd1;
        add_step(OP_WR, trap_pkg::CSR_EENTRY, 32'h1c00_0040, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_EENTRY, 32'h0, 7'h0, 32'h1c00_0040, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'hffff_ffff, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_ECFG, 32'h0, 7'h0, 32'h0000_1fff, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_PRMD, 32'h5, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_PRMD, 32'h0, 7'h0, 32'h5, 7'h0, 3'b000);
        add_step(OP_RD, 14'h3ff, 32'h0, 7'h0, 32'h0, 7'h1, 3'b000); // Unmapped address
        add_step(OP_WR, 14'h3ff, 32'hdead_beef, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_EENTRY, 32'h0, 7'h0, 32'h1c00_0040, 7'h0, 3'b000);

        tid = 3'd2;
        add_step(OP_WR, trap_pkg::CSR_CRMD, 32'h7, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_CRMD, 32'h0, 7'h0, 32'h7, 7'h0, 3'b000);
        add_step(OP_CMT, '0, 32'h1, 7'h0b, 32'h1c00_0040, 7'h1f, 3'b011);
        add_step(OP_RD, trap_pkg::CSR_ERA, 32'h0, 7'h0, 32'h0, 7'h0, 3'b100);
        add_step(OP_RD, trap_pkg::CSR_ESTAT, 32'h0, 7'h0, 32'h000b_0000, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_CRMD, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_PRMD, 32'h0, 7'h0, 32'h7, 7'h0, 3'b000);
        add_step(OP_CMT, '0, 32'h2, 7'h0, 32'h0, 7'h1f, 3'b101); // ertn back to ERA
        add_step(OP_RD, trap_pkg::CSR_CRMD, 32'h0, 7'h0, 32'h7, 7'h0, 3'b000);

        tid = 3'd3;
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'h4, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_HWI, '0, 32'h1, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_CMT, '0, 32'h0, 7'h0, 32'h1c00_0040, 7'h1f, 3'b011);
        add_step(OP_RD, trap_pkg::CSR_ESTAT, 32'h0, 7'h0, 32'h4, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_ERA, 32'h0, 7'h0, 32'h0, 7'h0, 3'b100);
        add_step(OP_RD, trap_pkg::CSR_CRMD, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_PRMD, 32'h0, 7'h0, 32'h7, 7'h0, 3'b000);
        add_step(OP_CMT, '0, 32'h0, 7'h0, 32'h0, 7'h0, 3'b010); // IE is 0 now
        add_step(OP_WR, trap_pkg::CSR_CRMD, 32'h4, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_CMT, '0, 32'h0, 7'h0, 32'h0, 7'h0, 3'b010); // LIE masks the line
        add_step(OP_HWI, '0, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);

        tid = 3'd4;
        add_step(OP_WR, trap_pkg::CSR_TCFG, 32'h21, 7'h0, 32'h0, 7'h0, 3'b000); // One-shot
        add_step(OP_WAIT, trap_pkg::CSR_ESTAT, 32'h800, 7'h0, 32'h800, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_TVAL, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_TICLR, 32'h1, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_ESTAT, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_RD, trap_pkg::CSR_TVAL, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);

        tid = 3'd5;
        add_step(OP_CMT, '0, 32'h4, 7'h0, 32'h0, 7'h0, 3'b000);
        for (int k = 0; k < 3; k++) add_step(OP_PROBE, '0, 32'h0, 7'h0, 32'h0, 7'h1, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ESTAT, 32'h1, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_PROBE, '0, 32'h0, 7'h0, 32'h0, 7'h1, 3'b000); // Not enabled yet
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'h1, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_WAIT, '0, 32'h1, 7'h1, 32'h0, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ESTAT, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);
        add_step(OP_WR, trap_pkg::CSR_ECFG, 32'h0, 7'h0, 32'h0, 7'h0, 3'b000);

        tid = 3'd6;
        add_step(OP_PROBE, '0, 32'h1, 7'h0, 32'h07, 7'h0, 3'b000); // if1..id
        add_step(OP_PROBE, '0, 32'h2, 7'h0, 32'h0f, 7'h0, 3'b000); // if1..ex
        add_step(OP_PROBE, '0, 32'h3, 7'h0, 32'h0f, 7'h0, 3'b000);
        for (int k = 1; k < trap_pkg::NUM_STAGES; k++) begin
            add_step(OP_PROBE, '0, 32'h0, 7'(1 << k), 32'h0, stall_from_req(7'(1 << k)),
                     3'b000);
        end
        add_step(OP_PROBE, '0, 32'h0, 7'h7e, 32'h0, stall_from_req(7'h7e), 3'b000);

        repeat (4) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        cur_test = 3'd0;
        foreach (steps[i]) begin
            if (steps[i].test != cur_test) begin
                if (cur_test != 3'd0) report_test(cur_test);
                cur_test  = steps[i].test;
                test_err0 = errors;
            end
            run_step(steps[i]);
        end
        report_test(cur_test);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/trap_pkg.sv
src/trap_csr_regs.sv
src/trap_timer.sv
src/trap_ctrl.sv
src/pipe_flush_ctrl.sv
src/trap_top.sv
testbench/tb_trap_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trap subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_trap_top -Mdir "$OBJ" -o sim_trap_top
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

"./$OBJ/sim_trap_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
exit 1
